//--- logic/vpu_bg_pkg.sv
package vpu_bg_pkg;

  // screen and layer geometry
  localparam int SCREEN_W    = 256;
  localparam int NUM_LAYERS  = 4;
  localparam int PARAM_WORDS = 2;
  localparam int PARAM_BASE  = 640;
  localparam int TILE_PIX    = 8;
  localparam int MAP_COLS    = 64;

  // line sequencing
  localparam int PARAM_LOAD_CYCLES = NUM_LAYERS * PARAM_WORDS + 1;
  localparam int DRAIN_CYCLES      = 5;

  // control word fields (word 0)
  localparam int CTRL_ENABLE   = 31;
  localparam int SCROLL_X_MSB  = 16;
  localparam int SCROLL_X_LSB  = 8;
  localparam int SCROLL_Y_MSB  = 7;
  localparam int SCROLL_Y_LSB  = 0;

  // bank word fields (word 1)
  localparam int TILE_BANK_MSB = 31;
  localparam int TILE_BANK_LSB = 28;
  localparam int MAP_BANK_MSB  = 27;
  localparam int MAP_BANK_LSB  = 24;
  localparam int PAL_MODE      = 6;
  localparam int PAL_BANK_MSB  = 5;
  localparam int PAL_BANK_LSB  = 4;
  localparam int PAL_NO_MSB    = 3;
  localparam int PAL_NO_LSB    = 0;

  // alpha lives in the top byte of a colour
  localparam int ALPHA_LSB     = 24;

  typedef logic [31:0] param_word_t;
  typedef logic [9:0]  param_addr_t;
  typedef logic [8:0]  pix_x_t;
  typedef logic [7:0]  pix_y_t;
  typedef logic [1:0]  layer_t;
  typedef logic [14:0] map_addr_t;
  typedef logic [9:0]  tile_idx_t;
  typedef logic [19:0] tile_addr_t;
  typedef logic [7:0]  pal_idx_t;
  typedef logic [9:0]  pal_addr_t;
  typedef logic [31:0] argb_t;

  typedef enum logic [2:0] {
    IDLE,
    PARAM,
    PIXELS,
    DRAIN,
    DONE
  } line_state_t;

endpackage

//--- logic/vpu_bg_line_ctrl.sv
module vpu_bg_line_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic render_req,
  output logic render_ack,
  output logic load_active,
  output logic issue_active,
  input  logic issue_last
);
  import vpu_bg_pkg::*;

  line_state_t state;
  logic [3:0]  phase_cnt;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= IDLE;
      phase_cnt <= '0;
    end else begin
      case (state)
        IDLE: begin
          phase_cnt <= '0;
          if (render_req) begin
            state <= PARAM;
          end
        end
        PARAM: begin
          // eight reads, then one cycle for the last word to land
          if (phase_cnt == PARAM_LOAD_CYCLES - 1) begin
            state     <= PIXELS;
            phase_cnt <= '0;
          end else begin
            phase_cnt <= phase_cnt + 1'b1;
          end
        end
        PIXELS: begin
          if (issue_last) begin
            state <= DRAIN;
          end
        end
        DRAIN: begin
          // let the last pixel leave the pipeline
          if (phase_cnt == DRAIN_CYCLES - 1) begin
            state     <= DONE;
            phase_cnt <= '0;
          end else begin
            phase_cnt <= phase_cnt + 1'b1;
          end
        end
        DONE: begin
          if (!render_req) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  assign load_active  = (state == PARAM);
  assign issue_active = (state == PIXELS);
  assign render_ack   = (state == DONE);

endmodule

//--- logic/vpu_bg_param_load.sv
module vpu_bg_param_load (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    load_active,
  output logic                    param_en,
  output vpu_bg_pkg::param_addr_t param_addr,
  input  vpu_bg_pkg::param_word_t param_dout,
  output vpu_bg_pkg::param_word_t ctrl_words [vpu_bg_pkg::NUM_LAYERS],
  output vpu_bg_pkg::param_word_t bank_words [vpu_bg_pkg::NUM_LAYERS]
);
  import vpu_bg_pkg::*;

  // read pointer, layer in the upper bits and word in bit 0
  logic [3:0] read_cnt;
  logic       capture;
  logic [2:0] capture_sel;
  layer_t     capture_layer;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      read_cnt <= '0;
      capture  <= 1'b0;
    end else begin
      capture <= param_en;
      if (!load_active) begin
        read_cnt <= '0;
      end else if (read_cnt != NUM_LAYERS * PARAM_WORDS) begin
        read_cnt <= read_cnt + 1'b1;
      end
    end
  end

  assign param_en   = load_active && (read_cnt < NUM_LAYERS * PARAM_WORDS);
  assign param_addr = param_addr_t'(PARAM_BASE + read_cnt);

  // remember which word the returning data belongs to
  always_ff @(posedge clk) begin
    capture_sel <= read_cnt[2:0];
  end

  assign capture_layer = layer_t'(capture_sel / PARAM_WORDS);

  always_ff @(posedge clk) begin
    if (capture) begin
      if (capture_sel % PARAM_WORDS == 0) begin
        ctrl_words[capture_layer] <= param_dout;
      end else begin
        bank_words[capture_layer] <= param_dout;
      end
    end
  end

endmodule

//--- logic/vpu_bg_scroll_stage.sv
module vpu_bg_scroll_stage (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    issue_active,
  output logic                    issue_last,
  input  vpu_bg_pkg::pix_y_t      line_y,
  input  vpu_bg_pkg::param_word_t ctrl_words [vpu_bg_pkg::NUM_LAYERS],
  input  vpu_bg_pkg::param_word_t bank_words [vpu_bg_pkg::NUM_LAYERS],
  output logic                    s0_valid,
  output vpu_bg_pkg::pix_x_t      s0_x,
  output vpu_bg_pkg::layer_t      s0_layer,
  output logic                    s0_enable,
  output vpu_bg_pkg::pix_x_t      s0_map_x,
  output vpu_bg_pkg::pix_y_t      s0_map_y,
  output vpu_bg_pkg::param_word_t s0_bank_word
);
  import vpu_bg_pkg::*;

  pix_x_t      x;
  layer_t      layer;
  param_word_t ctrl;

  // one layer per cycle, x steps after the top layer
  always_ff @(posedge clk) begin
    if (!rst_n || !issue_active) begin
      x     <= '0;
      layer <= '0;
    end else begin
      layer <= layer + 1'b1;
      if (layer == NUM_LAYERS - 1) begin
        x <= x + 1'b1;
      end
    end
  end

  assign issue_last = issue_active && (x == SCREEN_W - 1) && (layer == NUM_LAYERS - 1);
  assign ctrl       = ctrl_words[layer];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s0_valid <= 1'b0;
    end else begin
      s0_valid <= issue_active;
    end
  end

  // scrolled map position wraps at 512 in x and 256 in y
  always_ff @(posedge clk) begin
    s0_x         <= x;
    s0_layer     <= layer;
    s0_enable    <= ctrl[CTRL_ENABLE];
    s0_map_x     <= x - pix_x_t'(ctrl[SCROLL_X_MSB:SCROLL_X_LSB]);
    s0_map_y     <= line_y - pix_y_t'(ctrl[SCROLL_Y_MSB:SCROLL_Y_LSB]);
    s0_bank_word <= bank_words[layer];
  end

endmodule

//--- logic/vpu_bg_map_fetch.sv
module vpu_bg_map_fetch (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    s0_valid,
  input  vpu_bg_pkg::pix_x_t      s0_x,
  input  vpu_bg_pkg::layer_t      s0_layer,
  input  logic                    s0_enable,
  input  vpu_bg_pkg::pix_x_t      s0_map_x,
  input  vpu_bg_pkg::pix_y_t      s0_map_y,
  input  vpu_bg_pkg::param_word_t s0_bank_word,
  output logic                    map_en,
  output vpu_bg_pkg::map_addr_t   map_addr,
  input  vpu_bg_pkg::tile_idx_t   map_dout,
  output logic                    s1_valid,
  output vpu_bg_pkg::pix_x_t      s1_x,
  output vpu_bg_pkg::layer_t      s1_layer,
  output logic                    s1_enable,
  output logic [2:0]              s1_sub_x,
  output logic [2:0]              s1_sub_y,
  output vpu_bg_pkg::tile_idx_t   s1_tile_idx,
  output vpu_bg_pkg::param_word_t s1_bank_word
);
  import vpu_bg_pkg::*;

  logic [5:0] cell_col;
  logic [4:0] cell_row;

  assign cell_col = 6'((s0_map_x / TILE_PIX) % MAP_COLS);
  assign cell_row = 5'(s0_map_y / TILE_PIX);

  assign map_en   = s0_valid;
  assign map_addr = {s0_bank_word[MAP_BANK_MSB:MAP_BANK_LSB], 11'(cell_row * MAP_COLS + cell_col)};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= s0_valid;
    end
  end

  // sideband lines up with the map data
  always_ff @(posedge clk) begin
    s1_x         <= s0_x;
    s1_layer     <= s0_layer;
    s1_enable    <= s0_enable;
    s1_sub_x     <= 3'(s0_map_x % TILE_PIX);
    s1_sub_y     <= 3'(s0_map_y % TILE_PIX);
    s1_bank_word <= s0_bank_word;
  end

  assign s1_tile_idx = map_dout;

endmodule

//--- logic/vpu_bg_tile_fetch.sv
module vpu_bg_tile_fetch (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    s1_valid,
  input  vpu_bg_pkg::pix_x_t      s1_x,
  input  vpu_bg_pkg::layer_t      s1_layer,
  input  logic                    s1_enable,
  input  logic [2:0]              s1_sub_x,
  input  logic [2:0]              s1_sub_y,
  input  vpu_bg_pkg::tile_idx_t   s1_tile_idx,
  input  vpu_bg_pkg::param_word_t s1_bank_word,
  output logic                    tile_en,
  output vpu_bg_pkg::tile_addr_t  tile_addr,
  input  vpu_bg_pkg::pal_idx_t    tile_dout,
  output logic                    s2_valid,
  output vpu_bg_pkg::pix_x_t      s2_x,
  output vpu_bg_pkg::layer_t      s2_layer,
  output logic                    s2_enable,
  output vpu_bg_pkg::pal_idx_t    s2_pal_idx,
  output vpu_bg_pkg::param_word_t s2_bank_word
);
  import vpu_bg_pkg::*;

  // 64 pixels per tile, row major
  logic [15:0] tile_offset;

  assign tile_offset = 16'(s1_tile_idx * (TILE_PIX * TILE_PIX))
                     + 16'(s1_sub_y * TILE_PIX)
                     + 16'(s1_sub_x);

  assign tile_en   = s1_valid;
  assign tile_addr = {s1_bank_word[TILE_BANK_MSB:TILE_BANK_LSB], tile_offset};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s2_valid <= 1'b0;
    end else begin
      s2_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    s2_x         <= s1_x;
    s2_layer     <= s1_layer;
    s2_enable    <= s1_enable;
    s2_bank_word <= s1_bank_word;
  end

  assign s2_pal_idx = tile_dout;

endmodule

//--- logic/vpu_bg_palette_fetch.sv
module vpu_bg_palette_fetch (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    s2_valid,
  input  vpu_bg_pkg::pix_x_t      s2_x,
  input  vpu_bg_pkg::layer_t      s2_layer,
  input  logic                    s2_enable,
  input  vpu_bg_pkg::pal_idx_t    s2_pal_idx,
  input  vpu_bg_pkg::param_word_t s2_bank_word,
  output logic                    pal_en,
  output vpu_bg_pkg::pal_addr_t   pal_addr,
  input  vpu_bg_pkg::argb_t       pal_dout,
  output logic                    s3_valid,
  output vpu_bg_pkg::pix_x_t      s3_x,
  output vpu_bg_pkg::layer_t      s3_layer,
  output logic                    s3_enable,
  output vpu_bg_pkg::argb_t       s3_color
);
  import vpu_bg_pkg::*;

  logic [1:0] pal_bank;
  logic [3:0] pal_no;

  assign pal_bank = s2_bank_word[PAL_BANK_MSB:PAL_BANK_LSB];
  assign pal_no   = s2_bank_word[PAL_NO_MSB:PAL_NO_LSB];

  // mode 1 picks one of 16 sixteen-colour palettes
  always_comb begin
    if (s2_bank_word[PAL_MODE]) begin
      pal_addr = {pal_bank, pal_no, s2_pal_idx[3:0]};
    end else begin
      pal_addr = {pal_bank, s2_pal_idx};
    end
  end

  assign pal_en = s2_valid;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s3_valid <= 1'b0;
    end else begin
      s3_valid <= s2_valid;
    end
  end

  always_ff @(posedge clk) begin
    s3_x      <= s2_x;
    s3_layer  <= s2_layer;
    s3_enable <= s2_enable;
  end

  assign s3_color = pal_dout;

endmodule

//--- logic/vpu_bg_color_merge.sv
module vpu_bg_color_merge (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               s3_valid,
  input  vpu_bg_pkg::pix_x_t s3_x,
  input  vpu_bg_pkg::layer_t s3_layer,
  input  logic               s3_enable,
  input  vpu_bg_pkg::argb_t  s3_color,
  output logic               pixel_valid,
  output vpu_bg_pkg::pix_x_t pixel_x,
  output vpu_bg_pkg::argb_t  pixel_color
);
  import vpu_bg_pkg::*;

  argb_t dst;
  argb_t base;
  argb_t merged;

  // one layer over the running destination
  function automatic argb_t blend(argb_t under, argb_t src);
    logic [7:0]  alpha;
    logic [15:0] mix;
    argb_t       res;
    alpha = src[ALPHA_LSB +: 8];
    res   = under;
    if (alpha == 8'd255) begin
      res = src;
    end else if (alpha != 8'd0) begin
      for (int c = 0; c < 3; c++) begin
        mix = under[8*c +: 8] * (8'd255 - alpha) + src[8*c +: 8] * alpha;
        res[8*c +: 8] = mix[15:8];
      end
      res[ALPHA_LSB +: 8] = 8'((9'(under[ALPHA_LSB +: 8]) + 9'(alpha)) >> 1);
    end
    return res;
  endfunction

  // layer 0 starts from transparent black
  assign base   = (s3_layer == '0) ? '0 : dst;
  assign merged = s3_enable ? blend(base, s3_color) : base;

  always_ff @(posedge clk) begin
    if (s3_valid) begin
      dst <= merged;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pixel_valid <= 1'b0;
    end else begin
      pixel_valid <= s3_valid && (s3_layer == NUM_LAYERS - 1);
    end
  end

  // finished pixel after the top layer
  always_ff @(posedge clk) begin
    if (s3_valid && (s3_layer == NUM_LAYERS - 1)) begin
      pixel_x     <= s3_x;
      pixel_color <= merged;
    end
  end

endmodule

//--- logic/vpu_bg.sv
module vpu_bg (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    render_req,
  output logic                    render_ack,
  input  vpu_bg_pkg::pix_y_t      line_y,
  output logic                    param_en,
  output vpu_bg_pkg::param_addr_t param_addr,
  input  vpu_bg_pkg::param_word_t param_dout,
  output logic                    map_en,
  output vpu_bg_pkg::map_addr_t   map_addr,
  input  vpu_bg_pkg::tile_idx_t   map_dout,
  output logic                    tile_en,
  output vpu_bg_pkg::tile_addr_t  tile_addr,
  input  vpu_bg_pkg::pal_idx_t    tile_dout,
  output logic                    pal_en,
  output vpu_bg_pkg::pal_addr_t   pal_addr,
  input  vpu_bg_pkg::argb_t       pal_dout,
  output logic                    pixel_valid,
  output vpu_bg_pkg::pix_x_t      pixel_x,
  output vpu_bg_pkg::argb_t       pixel_color
);
  import vpu_bg_pkg::*;

  // sequencing
  logic        load_active;
  logic        issue_active;
  logic        issue_last;

  // per-layer parameters for the current line
  param_word_t ctrl_words [NUM_LAYERS];
  param_word_t bank_words [NUM_LAYERS];

  // scroll stage out
  logic        s0_valid;
  pix_x_t      s0_x;
  layer_t      s0_layer;
  logic        s0_enable;
  pix_x_t      s0_map_x;
  pix_y_t      s0_map_y;
  param_word_t s0_bank_word;

  // map data stage
  logic        s1_valid;
  pix_x_t      s1_x;
  layer_t      s1_layer;
  logic        s1_enable;
  logic [2:0]  s1_sub_x;
  logic [2:0]  s1_sub_y;
  tile_idx_t   s1_tile_idx;
  param_word_t s1_bank_word;

  // tile data stage
  logic        s2_valid;
  pix_x_t      s2_x;
  layer_t      s2_layer;
  logic        s2_enable;
  pal_idx_t    s2_pal_idx;
  param_word_t s2_bank_word;

  // palette data stage
  logic        s3_valid;
  pix_x_t      s3_x;
  layer_t      s3_layer;
  logic        s3_enable;
  argb_t       s3_color;

  vpu_bg_line_ctrl     u_line_ctrl     (.*);
  vpu_bg_param_load    u_param_load    (.*);
  vpu_bg_scroll_stage  u_scroll_stage  (.*);
  vpu_bg_map_fetch     u_map_fetch     (.*);
  vpu_bg_tile_fetch    u_tile_fetch    (.*);
  vpu_bg_palette_fetch u_palette_fetch (.*);
  vpu_bg_color_merge   u_color_merge   (.*);

endmodule

//--- sim/vpu_bg_ref.svh
`ifndef VPU_BG_REF_SVH
`define VPU_BG_REF_SVH

// memory images behind the DUT's four read ports
param_word_t param_mem [0:1023];
tile_idx_t   map_mem   [0:32767];
pal_idx_t    tile_mem  [0:4095];
argb_t       pal_mem   [0:1023];

task automatic fill_memories();
  int i;
  for (i = 0; i < 1024; i++) begin
    param_mem[i] = next_rand();
    pal_mem[i]   = next_rand();
  end
  for (i = 0; i < 32768; i++) begin
    map_mem[i] = tile_idx_t'(next_rand());
  end
  for (i = 0; i < 4096; i++) begin
    tile_mem[i] = pal_idx_t'(next_rand());
  end
endtask

// upper tile address bits fold into the data so every bank reads differently
function automatic pal_idx_t tile_read(int addr);
  return tile_mem[addr % 4096] ^ pal_idx_t'(addr / 4096);
endfunction

function automatic int map_index(param_word_t bank, int mx, int my);
  return int'(bank[27:24]) * 2048 + (my / 8) * 64 + mx / 8;
endfunction

function automatic int tile_index(param_word_t bank, int t_idx, int mx, int my);
  return int'(bank[31:28]) * 65536 + t_idx * 64 + (my % 8) * 8 + mx % 8;
endfunction

// 256-colour or sixteen palettes of 16
function automatic int pal_index(param_word_t bank, int p_idx);
  if (bank[6]) begin
    return int'(bank[5:4]) * 256 + int'(bank[3:0]) * 16 + p_idx % 16;
  end
  return int'(bank[5:4]) * 256 + p_idx;
endfunction

function automatic argb_t merge_layer(argb_t dst, argb_t src);
  int    a;
  int    ch;
  int    d;
  int    s;
  argb_t res;
  a = int'(src[31:24]);
  if (a == 0) begin
    return dst;
  end
  if (a == 255) begin
    return src;
  end
  for (ch = 0; ch < 3; ch++) begin
    d = int'(dst[8*ch +: 8]);
    s = int'(src[8*ch +: 8]);
    res[8*ch +: 8] = 8'((d * (255 - a) + s * a) / 256);
  end
  res[31:24] = 8'((int'(dst[31:24]) + a) / 2);
  return res;
endfunction

// expected colour of one screen pixel on line y
function automatic argb_t expect_pixel(int x, int y);
  argb_t       dst;
  param_word_t ctrl;
  param_word_t bank;
  int          l;
  int          mx;
  int          my;
  int          t_idx;
  int          p_idx;
  dst = '0;
  for (l = 0; l < NUM_LAYERS; l++) begin
    ctrl  = param_mem[PARAM_BASE + l * PARAM_WORDS];
    bank  = param_mem[PARAM_BASE + l * PARAM_WORDS + 1];
    mx    = (x - int'(ctrl[16:8]) + 512) % 512;
    my    = (y - int'(ctrl[7:0]) + 256) % 256;
    t_idx = int'(map_mem[map_index(bank, mx, my)]);
    p_idx = int'(tile_read(tile_index(bank, t_idx, mx, my)));
    if (ctrl[31]) begin
      dst = merge_layer(dst, pal_mem[pal_index(bank, p_idx)]);
    end
  end
  return dst;
endfunction

`endif

//--- sim/vpu_bg_tb.sv
module vpu_bg_tb;
  import vpu_bg_pkg::*;

  localparam int PIXEL_TIMEOUT = 64;
  localparam int ACK_TIMEOUT   = 16;
  localparam int IDLE_CHECK    = 4;

  logic        clk;
  logic        rst_n;
  logic        render_req;
  logic        render_ack;
  pix_y_t      line_y;
  logic        param_en;
  param_addr_t param_addr;
  param_word_t param_dout;
  logic        map_en;
  map_addr_t   map_addr;
  tile_idx_t   map_dout;
  logic        tile_en;
  tile_addr_t  tile_addr;
  pal_idx_t    tile_dout;
  logic        pal_en;
  pal_addr_t   pal_addr;
  argb_t       pal_dout;
  logic        pixel_valid;
  pix_x_t      pixel_x;
  argb_t       pixel_color;

  integer seed;
  int     err_cnt;
  int     test_cnt;
  int     test_fail_cnt;

  function automatic logic [31:0] next_rand();
    return $random(seed);
  endfunction

  `include "vpu_bg_ref.svh"

  vpu_bg DUT (.*);

  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  // all four memories answer on the clock after their enable
  always @(posedge clk) begin
    if (param_en) begin
      param_dout <= param_mem[param_addr];
    end
    if (map_en) begin
      map_dout <= map_mem[map_addr];
    end
    if (tile_en) begin
      tile_dout <= tile_read(tile_addr);
    end
    if (pal_en) begin
      pal_dout <= pal_mem[pal_addr];
    end
  end

  task automatic report_mismatch(input string sig, input logic [31:0] exp,
                                 input logic [31:0] got);
    err_cnt++;
    $display("mismatch at %0t: %s expected %h got %h", $time, sig, exp, got);
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("%0d tests run, %0d failed, %0d errors", test_cnt, test_fail_cnt, err_cnt);
    $display("Test FAILED");
    $finish;
  endtask

  task automatic end_test(input string name, input int errs_before);
    test_cnt++;
    if (err_cnt == errs_before) begin
      $display("%s: passed", name);
    end else begin
      test_fail_cnt++;
      $display("%s: %0d errors", name, err_cnt - errs_before);
    end
  endtask

  task automatic set_layer(input int l, input logic en, input logic mode);
    param_word_t ctrl;
    param_word_t bank;
    ctrl        = '0;
    ctrl[31]    = en;
    ctrl[16:8]  = 9'(next_rand());
    ctrl[7:0]   = 8'(next_rand());
    bank        = '0;
    bank[31:28] = 4'(next_rand());
    bank[27:24] = 4'(next_rand());
    bank[6]     = mode;
    bank[5:4]   = 2'(next_rand());
    bank[3:0]   = 4'(next_rand());
    param_mem[PARAM_BASE + l * PARAM_WORDS]     = ctrl;
    param_mem[PARAM_BASE + l * PARAM_WORDS + 1] = bank;
  endtask

  // one full req/ack exchange, checking every pixel on the way
  task automatic render_line(input pix_y_t y);
    int    n_pix;
    int    wait_cnt;
    int    i;
    bit    got_ack;
    argb_t exp_color;
    @(posedge clk);
    render_req <= 1'b1;
    line_y     <= y;
    n_pix    = 0;
    wait_cnt = 0;
    got_ack  = 1'b0;
    while (!got_ack) begin
      @(negedge clk);
      if (pixel_valid) begin
        exp_color = expect_pixel(n_pix, int'(y));
        if (pixel_x !== pix_x_t'(n_pix)) begin
          report_mismatch("pixel_x", 32'(n_pix), 32'(pixel_x));
        end
        if (pixel_color !== exp_color) begin
          report_mismatch("pixel_color", exp_color, pixel_color);
        end
        n_pix++;
        wait_cnt = 0;
      end else begin
        wait_cnt++;
      end
      if (render_ack) begin
        got_ack = 1'b1;
        // ack comes on the cycle right after the last pixel
        if (wait_cnt != 1) begin
          err_cnt++;
          $display("render_ack rose %0d cycles after the last pixel instead of 1 at %0t",
                   wait_cnt, $time);
        end
      end else if (n_pix > SCREEN_W) begin
        abort_run($sformatf("line %0d gave more than %0d pixels without render_ack",
                            y, SCREEN_W));
      end else if (wait_cnt > PIXEL_TIMEOUT) begin
        abort_run($sformatf("timeout waiting for a pixel or render_ack on line %0d", y));
      end
    end
    if (n_pix != SCREEN_W) begin
      err_cnt++;
      $display("line %0d gave %0d pixels instead of %0d", y, n_pix, SCREEN_W);
    end
    @(posedge clk);
    render_req <= 1'b0;
    wait_cnt = 0;
    while (render_ack) begin
      @(negedge clk);
      wait_cnt++;
      if (wait_cnt > ACK_TIMEOUT) begin
        abort_run($sformatf("render_ack did not fall after the request dropped, line %0d", y));
      end
    end
    // the DUT sees the dropped request on the next edge and clears ack there
    if (wait_cnt != 2) begin
      err_cnt++;
      $display("render_ack fell %0d cycles after render_req dropped instead of 1",
               wait_cnt - 1);
    end
    // no second ack and no stray pixels while idle
    for (i = 0; i < IDLE_CHECK; i++) begin
      @(negedge clk);
      if (render_ack !== 1'b0) begin
        report_mismatch("render_ack", 32'd0, render_ack);
      end
      if (pixel_valid !== 1'b0) begin
        report_mismatch("pixel_valid", 32'd0, pixel_valid);
      end
    end
  endtask

  initial begin
    int          errs;
    int          i;
    int          l;
    logic [31:0] mask;
    seed          = 32'h90d1;
    err_cnt       = 0;
    test_cnt      = 0;
    test_fail_cnt = 0;
    rst_n         = 1'b0;
    render_req    = 1'b0;
    line_y        = '0;
    param_dout    = '0;
    map_dout      = '0;
    tile_dout     = '0;
    pal_dout      = '0;
    fill_memories();
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;

    errs = err_cnt;
    @(negedge clk);
    if (render_ack !== 1'b0) begin
      report_mismatch("render_ack", 32'd0, render_ack);
    end
    if (pixel_valid !== 1'b0) begin
      report_mismatch("pixel_valid", 32'd0, pixel_valid);
    end
    if (param_en !== 1'b0) begin
      report_mismatch("param_en", 32'd0, param_en);
    end
    if (map_en !== 1'b0) begin
      report_mismatch("map_en", 32'd0, map_en);
    end
    if (tile_en !== 1'b0) begin
      report_mismatch("tile_en", 32'd0, tile_en);
    end
    if (pal_en !== 1'b0) begin
      report_mismatch("pal_en", 32'd0, pal_en);
    end
    for (l = 0; l < NUM_LAYERS; l++) begin
      set_layer(l, 1'b1, 1'b0);
    end
    render_line(pix_y_t'(next_rand()));
    end_test("handshake", errs);

    errs = err_cnt;
    for (i = 0; i < 3; i++) begin
      for (l = 0; l < NUM_LAYERS; l++) begin
        set_layer(l, 1'b1, 1'b0);
      end
      render_line(pix_y_t'(next_rand()));
    end
    end_test("full line mode 0", errs);

    errs = err_cnt;
    for (i = 0; i < 3; i++) begin
      for (l = 0; l < NUM_LAYERS; l++) begin
        set_layer(l, 1'b1, 1'b1);
      end
      render_line(pix_y_t'(next_rand()));
    end
    end_test("mode 1 palettes", errs);

    // banks 1 and 3 fully transparent, bank 2 fully opaque
    errs = err_cnt;
    for (i = 256; i < 1024; i++) begin
      pal_mem[i][31:24] = (i >= 512 && i < 768) ? 8'd255 : 8'd0;
    end
    for (l = 0; l < NUM_LAYERS; l++) begin
      set_layer(l, 1'b1, 1'b0);
      param_mem[PARAM_BASE + l * PARAM_WORDS + 1][5:4] = 2'(l);
    end
    render_line(pix_y_t'(next_rand()));
    param_mem[PARAM_BASE + 3 * PARAM_WORDS + 1][5:4] = 2'd2;
    render_line(pix_y_t'(next_rand()));
    end_test("alpha extremes", errs);
    for (i = 0; i < 1024; i++) begin
      pal_mem[i] = next_rand();
    end

    errs = err_cnt;
    for (i = 0; i < 4; i++) begin
      mask = next_rand();
      for (l = 0; l < NUM_LAYERS; l++) begin
        set_layer(l, mask[l], mask[l + 4]);
      end
      render_line(pix_y_t'(next_rand()));
    end
    end_test("layer enables", errs);

    // edge lines first, then random ones
    errs = err_cnt;
    for (i = 0; i < 10; i++) begin
      for (l = 0; l < NUM_LAYERS; l++) begin
        mask = next_rand();
        set_layer(l, mask[1:0] != 2'd0, mask[2]);
      end
      if (i == 0) begin
        render_line(8'd255);
      end else if (i == 1) begin
        render_line(8'd0);
      end else begin
        render_line(pix_y_t'(next_rand()));
      end
    end
    end_test("back-to-back lines", errs);

    $display("%0d tests run, %0d failed, %0d errors", test_cnt, test_fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- project.f
+incdir+sim
logic/vpu_bg_pkg.sv
logic/vpu_bg_line_ctrl.sv
logic/vpu_bg_param_load.sv
logic/vpu_bg_scroll_stage.sv
logic/vpu_bg_map_fetch.sv
logic/vpu_bg_tile_fetch.sv
logic/vpu_bg_palette_fetch.sv
logic/vpu_bg_color_merge.sv
logic/vpu_bg.sv
sim/vpu_bg_tb.sv

//--- Bender.yml
package:
  name: vpu_bg

sources:
  - files:
      - logic/vpu_bg_pkg.sv
      - logic/vpu_bg_line_ctrl.sv
      - logic/vpu_bg_param_load.sv
      - logic/vpu_bg_scroll_stage.sv
      - logic/vpu_bg_map_fetch.sv
      - logic/vpu_bg_tile_fetch.sv
      - logic/vpu_bg_palette_fetch.sv
      - logic/vpu_bg_color_merge.sv
      - logic/vpu_bg.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/vpu_bg_tb.sv
